// File: Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - psel_gen.sv
      - phys_reg_status.sv
      - branch_stack.sv
      - dispatch.sv
      - rename_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rename_assert.sv
      - rename_tb.sv

// File: branch_stack.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module branch_stack (
    input  logic                                     clock,
    input  logic                                     reset,
    input  rename_pkg::b_mask_t                      bs_alloc,
    input  rename_pkg::checkpoint_t [`BS_DEPTH-1:0]  new_checkpoints,
    input  logic                                     resolve_valid,
    input  logic                                     resolve_mispredict,
    input  rename_pkg::b_id_t                        resolve_id,
    input  logic                                     retire_valid,
    input  rename_pkg::phys_reg_t                    retire_tag,
    output rename_pkg::b_mask_t                      b_mask,
    output logic                                     restore_valid,
    output rename_pkg::map_table_t                   restore_map,
    output rename_pkg::reg_vec_t                     restore_free
);
    import rename_pkg::*;

    bs_state_t                     state [`BS_DEPTH];
    bs_state_t                     next_state [`BS_DEPTH];
    checkpoint_t [`BS_DEPTH-1:0]   cps, next_cps;

    always_comb begin
        for (int j = 0; j < `BS_DEPTH; j++) b_mask[j] = (state[j] == bs_live);
    end

    assign restore_valid = resolve_valid && resolve_mispredict;
    assign restore_map   = cps[resolve_id].map_table;
    assign restore_free  = cps[resolve_id].free_list;  // retire of this cycle added downstream

    always_comb begin
        next_state = state;
        next_cps = cps;
        for (int j = 0; j < `BS_DEPTH; j++) begin
            if (bs_alloc[j]) begin
                next_state[j] = bs_live;
                next_cps[j] = new_checkpoints[j];
            end
            if (retire_valid && next_state[j] == bs_live) next_cps[j].free_list[retire_tag] = 1'b1;
            // a resolved branch is no longer an older dependency of anyone
            if (resolve_valid && !resolve_mispredict) next_cps[j].b_mask[resolve_id] = 1'b0;
        end
        if (resolve_valid) begin
            next_state[resolve_id] = bs_empty;
            for (int j = 0; j < `BS_DEPTH; j++) begin
                // younger entries are those outside the mispredicted branch's mask
                if (resolve_mispredict && !cps[resolve_id].b_mask[j]) next_state[j] = bs_empty;
            end
        end
    end

    always_ff @(posedge clock) begin
        cps <= next_cps;
        for (int j = 0; j < `BS_DEPTH; j++) state[j] <= reset ? bs_empty : next_state[j];
    end

endmodule

// File: build.f
+incdir+.
rename_pkg.sv
psel_gen.sv
phys_reg_status.sv
branch_stack.sv
dispatch.sv
rename_top.sv
rename_assert.sv
rename_tb.sv

// File: dispatch.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module dispatch (
    input  logic                                     clock,
    input  logic                                     reset,
    input  rename_pkg::count_t                       inst_count,
    input  rename_pkg::count_t                       rob_spots,
    input  rename_pkg::count_t                       rs_spots,
    input  rename_pkg::count_t                       free_count,
    input  rename_pkg::decoded_t  [`RN_WIDTH-1:0]    insts,
    input  rename_pkg::phys_reg_t [`RN_WIDTH-1:0]    regs_to_use,
    input  rename_pkg::reg_vec_t                     complete_list,
    input  rename_pkg::reg_vec_t                     free_list,
    input  rename_pkg::cdb_t      [`RN_WIDTH-1:0]    cdb,
    input  rename_pkg::b_mask_t                      b_mask,
    input  logic                                     restore_valid,
    input  rename_pkg::map_table_t                   restore_map,
    output rename_pkg::count_t                       num_dispatched,
    output rename_pkg::count_t                       alloc_count,
    output rename_pkg::rs_entry_t  [`RN_WIDTH-1:0]   rs_entries,
    output rename_pkg::rob_entry_t [`RN_WIDTH-1:0]   rob_entries,
    output rename_pkg::b_mask_t                      bs_alloc,
    output rename_pkg::checkpoint_t [`BS_DEPTH-1:0]  new_checkpoints
);
    import rename_pkg::*;

    map_table_t                map_table, next_map;
    reg_vec_t                  next_free;
    reg_vec_t                  ready_list;  // completion list minus this cycle's new tags
    b_mask_t                   next_mask;
    b_mask_t [`RN_WIDTH-1:0]   slot_gnt;    // free branch-stack slots, lowest first
    count_t                    limit;
    count_t                    branches;
    logic                      stop;

    // a source is ready if unused, already complete, or completing right now
    function automatic logic src_ready(input phys_reg_t tag, input logic used,
                                       input reg_vec_t done, input cdb_t [`RN_WIDTH-1:0] bus);
        logic ready;
        ready = !used || done[tag];
        for (int j = 0; j < `RN_WIDTH; j++) begin
            if (bus[j].valid && bus[j].tag == tag) ready = 1'b1;
        end
        return ready;
    endfunction

    psel_gen #(
        .WIDTH (`BS_DEPTH),
        .REQS  (`RN_WIDTH)
    ) i_psel_gen (
        .req     (~b_mask),
        .gnt_bus (slot_gnt)
    );

    always_comb begin
        limit = inst_count;
        if (rob_spots < limit) limit = rob_spots;
        if (rs_spots < limit) limit = rs_spots;
        if (free_count < limit) limit = free_count;
        if (restore_valid) limit = '0;  // nothing dispatches while recovering
    end

    always_comb begin
        next_map = map_table;
        next_free = free_list;
        ready_list = complete_list;
        next_mask = b_mask;
        num_dispatched = '0;
        bs_alloc = '0;
        new_checkpoints = '0;
        rs_entries = '0;
        rob_entries = '0;
        branches = '0;
        stop = 1'b0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (i < limit && !stop) begin
                if (insts[i].is_branch && slot_gnt[branches] == '0) begin
                    stop = 1'b1;  // no checkpoint slot left, hold this and later lanes
                end else begin
                    // sources see renames of earlier lanes
                    rs_entries[i].t_new = regs_to_use[i];
                    rs_entries[i].src1 = next_map[insts[i].src1];
                    rs_entries[i].src1_ready = src_ready(next_map[insts[i].src1],
                                                         insts[i].rs1_used, ready_list, cdb);
                    rs_entries[i].src2 = next_map[insts[i].src2];
                    rs_entries[i].src2_ready = src_ready(next_map[insts[i].src2],
                                                         insts[i].rs2_used, ready_list, cdb);
                    rs_entries[i].b_mask = next_mask;

                    rob_entries[i].t_new = regs_to_use[i];
                    rob_entries[i].arch_reg = insts[i].has_dest ? insts[i].dest : '0;
                    rob_entries[i].t_old = insts[i].has_dest ? next_map[insts[i].dest]
                                                             : regs_to_use[i];
                    rob_entries[i].halt = insts[i].halt;

                    next_free[regs_to_use[i]] = 1'b0;
                    ready_list[regs_to_use[i]] = 1'b0;
                    if (insts[i].has_dest) next_map[insts[i].dest] = regs_to_use[i];

                    if (insts[i].is_branch) begin
                        // snapshot state after this branch's own rename
                        for (int j = 0; j < `BS_DEPTH; j++) begin
                            if (slot_gnt[branches][j]) begin
                                new_checkpoints[j].map_table = next_map;
                                new_checkpoints[j].free_list = next_free;
                                new_checkpoints[j].b_mask = next_mask;
                            end
                        end
                        rs_entries[i].b_mask_mask = slot_gnt[branches];
                        bs_alloc = bs_alloc | slot_gnt[branches];
                        next_mask = next_mask | slot_gnt[branches];
                        branches = branches + 1'b1;
                    end
                    num_dispatched = num_dispatched + 1'b1;
                end
            end
        end
    end

    assign alloc_count = num_dispatched;  // one new register per dispatched lane

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) map_table[a] <= phys_reg_t'(a);  // identity
        end else begin
            map_table <= restore_valid ? restore_map : next_map;
        end
    end

endmodule

// File: phys_reg_status.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module phys_reg_status (
    input  logic                                     clock,
    input  logic                                     reset,
    input  rename_pkg::count_t                       alloc_count,
    input  rename_pkg::cdb_t  [`RN_WIDTH-1:0]        cdb,
    input  logic                                     retire_valid,
    input  rename_pkg::phys_reg_t                    retire_tag,
    input  logic                                     restore_valid,
    input  rename_pkg::reg_vec_t                     restore_free,
    output rename_pkg::phys_reg_t [`RN_WIDTH-1:0]    regs_to_use,
    output rename_pkg::count_t                       free_count,
    output rename_pkg::reg_vec_t                     free_list,
    output rename_pkg::reg_vec_t                     complete_list
);
    import rename_pkg::*;

    count_t   found;
    reg_vec_t next_free, next_complete;

    // pick the lowest free registers, stop once RN_WIDTH are found
    always_comb begin
        regs_to_use = '0;
        found = '0;
        for (int p = 0; p < `PHYS_REGS; p++) begin
            if (free_list[p] && found < `RN_WIDTH) begin
                regs_to_use[found] = phys_reg_t'(p);
                found = found + 1'b1;
            end
        end
    end

    assign free_count = found;  // saturates at RN_WIDTH

    always_comb begin
        next_free = restore_valid ? restore_free : free_list;
        next_complete = complete_list;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (i < alloc_count) begin
                next_free[regs_to_use[i]] = 1'b0;
                next_complete[regs_to_use[i]] = 1'b0;  // new tag is not yet written
            end
            if (cdb[i].valid) next_complete[cdb[i].tag] = 1'b1;
        end
        if (retire_valid) next_free[retire_tag] = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `PHYS_REGS; p++) begin
                free_list[p] <= (p >= `ARCH_REGS);     // upper half starts free
                complete_list[p] <= (p < `ARCH_REGS);  // initial mappings hold values
            end
        end else begin
            free_list <= next_free;
            complete_list <= next_complete;
        end
    end

endmodule

// File: psel_gen.sv
`timescale 1ns/1ps

// grants up to REQS requests, lowest index first, each grant one-hot
module psel_gen #(
    parameter int WIDTH = 4,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    logic [REQS-1:0][WIDTH-1:0] left;  // requests not yet granted before grant k

    assign left[0] = req;

    for (genvar k = 0; k < REQS; k++) begin : g_grant
        // lowest set bit of what is left, zero if nothing is left
        assign gnt_bus[k] = left[k] & (~left[k] + 1'b1);

        if (k < REQS - 1) begin : g_next
            assign left[k+1] = left[k] & ~gnt_bus[k];
        end
    end

endmodule

// File: rename_assert.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module dispatch_assert (
    input logic                                  clock,
    input logic                                  reset,
    input rename_pkg::count_t                    inst_count,
    input rename_pkg::count_t                    rob_spots,
    input rename_pkg::count_t                    rs_spots,
    input rename_pkg::count_t                    free_count,
    input rename_pkg::count_t                    num_dispatched,
    input rename_pkg::count_t                    alloc_count,
    input rename_pkg::phys_reg_t [`RN_WIDTH-1:0] regs_to_use,
    input logic                                  restore_valid,
    input rename_pkg::b_mask_t                   bs_alloc,
    input rename_pkg::b_mask_t                   b_mask
);
    int violations = 0;  // read by the testbench at the end of the run

    count_limit: assert property (@(posedge clock) disable iff (reset)
        num_dispatched <= inst_count && num_dispatched <= rob_spots &&
        num_dispatched <= rs_spots && num_dispatched <= free_count)
        else begin
            violations++;
            $error("dispatch count above one of its limits");
        end

    no_dispatch_on_restore: assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> num_dispatched == '0)
        else begin
            violations++;
            $error("instructions dispatched during a restore");
        end

    distinct_tags: assert property (@(posedge clock) disable iff (reset)
        alloc_count > 1 |-> regs_to_use[0] != regs_to_use[1])
        else begin
            violations++;
            $error("same physical register allocated twice in one cycle");
        end

    slot_is_free: assert property (@(posedge clock) disable iff (reset)
        (bs_alloc & b_mask) == '0)
        else begin
            violations++;
            $error("branch-stack entry allocated while still live");
        end

endmodule

bind dispatch dispatch_assert i_dispatch_assert (
    .clock, .reset, .inst_count, .rob_spots, .rs_spots, .free_count, .num_dispatched,
    .alloc_count, .regs_to_use, .restore_valid, .bs_alloc, .b_mask
);

// File: rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;  // architectural register index
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;  // physical register tag
    typedef logic [`PHYS_REGS-1:0]         reg_vec_t;   // one bit per physical register
    typedef logic [`BS_DEPTH-1:0]          b_mask_t;    // one bit per branch-stack entry
    typedef logic [$clog2(`BS_DEPTH)-1:0]  b_id_t;
    typedef logic [`CNT_BITS-1:0]          count_t;
    typedef phys_reg_t [`ARCH_REGS-1:0]    map_table_t;

    typedef struct packed {
        logic      has_dest;
        logic      is_branch;
        logic      halt;
        logic      rs1_used;
        logic      rs2_used;
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
    } decoded_t;

    typedef struct packed {
        phys_reg_t t_new;
        phys_reg_t src1;
        logic      src1_ready;
        phys_reg_t src2;
        logic      src2_ready;
        b_mask_t   b_mask;       // branches this entry depends on
        b_mask_t   b_mask_mask;  // own bit, set for a branch only
    } rs_entry_t;

    typedef struct packed {
        phys_reg_t t_new;
        phys_reg_t t_old;   // freed when this entry retires
        arch_reg_t arch_reg;
        logic      halt;
    } rob_entry_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t tag;
    } cdb_t;

    typedef struct packed {
        map_table_t map_table;
        reg_vec_t   free_list;
        b_mask_t    b_mask;
    } checkpoint_t;

    typedef enum logic {
        bs_empty,
        bs_live
    } bs_state_t;

endpackage

// File: rename_settings.svh
`ifndef rename_settings_svh
`define rename_settings_svh

// instructions renamed per cycle
`define RN_WIDTH 2

// register file sizes
`define ARCH_REGS 8
`define PHYS_REGS 16

// checkpoints held for unresolved branches
`define BS_DEPTH 2

// a dispatch count runs from 0 up to RN_WIDTH
`define CNT_BITS 2

`endif

// File: rename_tb.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int TEST_CYCLES = 250;
    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = (NUM_TESTS * (TEST_CYCLES + 1) + 10 + 100) * 20;

    logic                        clock, reset;
    count_t                      inst_count, rob_spots, rs_spots, num_dispatched;
    decoded_t   [`RN_WIDTH-1:0]  insts;
    rs_entry_t  [`RN_WIDTH-1:0]  rs_entries;
    rob_entry_t [`RN_WIDTH-1:0]  rob_entries;
    b_mask_t                     b_mask;
    cdb_t       [`RN_WIDTH-1:0]  cdb;
    logic                        retire_valid, resolve_valid, resolve_mispredict;
    phys_reg_t                   retire_tag;
    b_id_t                       resolve_id;

    // reference state, valid for the cycle being checked
    map_table_t  m_map;
    reg_vec_t    m_free, m_complete;
    b_mask_t     m_live;
    checkpoint_t m_cp [`BS_DEPTH];
    phys_reg_t   retire_q [$];  // old tags waiting to retire
    count_t      exp_count;
    rs_entry_t   exp_rs [`RN_WIDTH];
    rob_entry_t  exp_rob [`RN_WIDTH];
    b_mask_t     exp_mask;
    logic [15:0] lfsr;
    int          errors, checks, total;

    rename_top i_rename_top (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] bits;
        logic       fb;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[6:0], fb};
        end
        return bits;
    endfunction

    function automatic logic ready_now(input phys_reg_t tag, input logic used,
                                       input reg_vec_t done);
        logic ready;
        ready = !used || done[tag];
        for (int l = 0; l < `RN_WIDTH; l++) begin
            if (cdb[l].valid && cdb[l].tag == tag) ready = 1'b1;  // same-cycle wakeup
        end
        return ready;
    endfunction

    function automatic void reset_model();
        for (int a = 0; a < `ARCH_REGS; a++) m_map[a] = phys_reg_t'(a);
        for (int p = 0; p < `PHYS_REGS; p++) begin
            m_free[p] = (p >= `ARCH_REGS);
            m_complete[p] = (p < `ARCH_REGS);
        end
        m_live = '0;
        for (int j = 0; j < `BS_DEPTH; j++) m_cp[j] = '0;
        retire_q.delete();
    endfunction

    // expected outputs of this cycle, then the state after the next edge
    function automatic void model_step();
        phys_reg_t   tags [`RN_WIDTH];
        int          slots [`BS_DEPTH];
        int          n_tags, n_slots, k, lim;
        map_table_t  wmap;
        reg_vec_t    wfree, wdone;
        b_mask_t     mask, next_live;
        logic        restore, stop;
        checkpoint_t cp [`BS_DEPTH];
        n_tags = 0;
        n_slots = 0;
        for (int p = 0; p < `PHYS_REGS; p++) begin
            if (m_free[p] && n_tags < `RN_WIDTH) begin
                tags[n_tags] = phys_reg_t'(p);
                n_tags++;
            end
        end
        for (int j = 0; j < `BS_DEPTH; j++) begin
            if (!m_live[j]) begin
                slots[n_slots] = j;
                n_slots++;
            end
        end
        restore = resolve_valid && resolve_mispredict;
        lim = inst_count;
        if (rob_spots < lim) lim = rob_spots;
        if (rs_spots < lim) lim = rs_spots;
        if (n_tags < lim) lim = n_tags;
        if (restore) lim = 0;
        exp_mask = m_live;
        exp_count = '0;
        wmap = m_map;
        wfree = m_free;
        wdone = m_complete;
        mask = m_live;
        cp = m_cp;
        k = 0;
        stop = 1'b0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            exp_rs[i] = '0;
            exp_rob[i] = '0;
            if (i < lim && !stop) begin
                if (insts[i].is_branch && k >= n_slots) begin
                    stop = 1'b1;
                end else begin
                    exp_rs[i].t_new = tags[i];
                    exp_rs[i].src1 = wmap[insts[i].src1];
                    exp_rs[i].src1_ready = ready_now(exp_rs[i].src1, insts[i].rs1_used, wdone);
                    exp_rs[i].src2 = wmap[insts[i].src2];
                    exp_rs[i].src2_ready = ready_now(exp_rs[i].src2, insts[i].rs2_used, wdone);
                    exp_rs[i].b_mask = mask;
                    exp_rob[i].t_new = tags[i];
                    exp_rob[i].t_old = insts[i].has_dest ? wmap[insts[i].dest] : tags[i];
                    exp_rob[i].arch_reg = insts[i].has_dest ? insts[i].dest : '0;
                    exp_rob[i].halt = insts[i].halt;
                    retire_q.push_back(exp_rob[i].t_old);
                    wfree[tags[i]] = 1'b0;
                    wdone[tags[i]] = 1'b0;
                    if (insts[i].has_dest) wmap[insts[i].dest] = tags[i];
                    if (insts[i].is_branch) begin
                        cp[slots[k]].map_table = wmap;
                        cp[slots[k]].free_list = wfree;
                        cp[slots[k]].b_mask = mask;
                        exp_rs[i].b_mask_mask[slots[k]] = 1'b1;
                        mask[slots[k]] = 1'b1;
                        k++;
                    end
                    exp_count = exp_count + 1'b1;
                end
            end
        end
        if (restore) begin
            m_map = m_cp[resolve_id].map_table;
            wfree = m_cp[resolve_id].free_list;
            next_live = m_live & m_cp[resolve_id].b_mask;  // only older branches survive
        end else begin
            m_map = wmap;
            next_live = mask;
            if (resolve_valid) begin
                next_live[resolve_id] = 1'b0;
                for (int j = 0; j < `BS_DEPTH; j++) cp[j].b_mask[resolve_id] = 1'b0;
            end
        end
        if (retire_valid) begin
            wfree[retire_tag] = 1'b1;
            for (int j = 0; j < `BS_DEPTH; j++) begin
                if (next_live[j]) cp[j].free_list[retire_tag] = 1'b1;
            end
        end
        for (int l = 0; l < `RN_WIDTH; l++) begin
            if (cdb[l].valid) wdone[cdb[l].tag] = 1'b1;
        end
        m_free = wfree;
        m_complete = wdone;
        m_live = next_live;
        m_cp = cp;
    endfunction

    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rs(input string name, input rs_entry_t got, input rs_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rob(input string name, input rob_entry_t got, input rob_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mask(input string name, input b_mask_t got, input b_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_idle();
        inst_count = '0;
        rob_spots = '0;
        rs_spots = '0;
        insts = '0;
        cdb = '0;
        retire_valid = 1'b0;
        retire_tag = '0;
        resolve_valid = 1'b0;
        resolve_mispredict = 1'b0;
        resolve_id = '0;
    endtask

    // mode 0 count, 1 rename, 2 readiness, 3 branches, 4 recovery
    task automatic drive_random(input int mode);
        logic [7:0] r;
        drive_idle();
        r = take_bits(2);
        inst_count = (r == 3) ? count_t'(2) : count_t'(r);
        rob_spots = 2'd3;
        rs_spots = 2'd3;
        if (mode == 0 || take_bits(2) == 0) begin
            rob_spots = count_t'(take_bits(2));
            rs_spots = count_t'(take_bits(2));
        end
        for (int i = 0; i < `RN_WIDTH; i++) begin
            insts[i].has_dest = take_bits(2) != 0;
            insts[i].is_branch = mode >= 3 && take_bits(1) != 0;
            insts[i].halt = take_bits(3) == 0;
            insts[i].rs1_used = take_bits(2) != 0;
            insts[i].rs2_used = take_bits(1) != 0;
            insts[i].src1 = arch_reg_t'(take_bits(3));
            insts[i].src2 = arch_reg_t'(take_bits(3));
            insts[i].dest = arch_reg_t'(take_bits(3));
        end
        if (mode == 1) begin
            if (take_bits(1) != 0) insts[1].src1 = insts[0].dest;  // lane 1 reads lane 0
            if (take_bits(1) != 0) insts[1].dest = insts[0].dest;
        end
        for (int l = 0; l < `RN_WIDTH; l++) begin
            r = take_bits(4);
            cdb[l].tag = phys_reg_t'(r);
            cdb[l].valid = (mode == 2 || mode == 4) && take_bits(1) != 0 && !m_free[r[3:0]];
        end
        while (retire_q.size() > 0 && m_free[retire_q[0]]) void'(retire_q.pop_front());
        if (retire_q.size() > 0 && take_bits(2) != 0) begin
            retire_valid = 1'b1;
            retire_tag = retire_q.pop_front();
        end
        if (m_live != '0 && ((mode == 3 && take_bits(3) == 0) ||
                             (mode == 4 && take_bits(2) == 0))) begin
            resolve_id = b_id_t'(take_bits(1));
            if (!m_live[resolve_id]) resolve_id = ~resolve_id;
            resolve_valid = 1'b1;
            resolve_mispredict = mode == 4 && take_bits(1) != 0;
        end
    endtask

    task automatic run_test(input string name, input int mode);
        int errors_before, checks_before;
        errors_before = errors;
        checks_before = checks;
        for (int c = 0; c <= TEST_CYCLES; c++) begin
            @(posedge clock);
            #2;
            if (c < TEST_CYCLES) drive_random(mode);
            else drive_idle();  // last cycle lets the final check land
        end
        $display("%-10s %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    // compare process, sampled mid-cycle
    initial begin
        wait (reset == 1'b0);
        forever begin
            @(negedge clock);
            model_step();
            check_mask("b_mask", b_mask, exp_mask);
            check_count("num_dispatched", num_dispatched, exp_count);
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (i < exp_count) begin
                    check_rs($sformatf("rs_entries[%0d]", i), rs_entries[i], exp_rs[i]);
                    check_rob($sformatf("rob_entries[%0d]", i), rob_entries[i], exp_rob[i]);
                end
            end
        end
    end

    initial begin
        errors = 0;
        checks = 0;
        lfsr = 16'd69;
        reset = 1'b1;
        drive_idle();
        reset_model();
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        run_test("count", 0);
        run_test("rename", 1);
        run_test("readiness", 2);
        run_test("branches", 3);
        run_test("recovery", 4);
        @(posedge clock);
        total = errors + i_rename_top.i_dispatch.i_dispatch_assert.violations;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 i_rename_top.i_dispatch.i_dispatch_assert.violations);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: rename_top.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_top (
    input  logic                                     clock,
    input  logic                                     reset,
    input  rename_pkg::count_t                       inst_count,
    input  rename_pkg::decoded_t   [`RN_WIDTH-1:0]   insts,
    input  rename_pkg::count_t                       rob_spots,
    input  rename_pkg::count_t                       rs_spots,
    output rename_pkg::count_t                       num_dispatched,
    output rename_pkg::rs_entry_t  [`RN_WIDTH-1:0]   rs_entries,
    output rename_pkg::rob_entry_t [`RN_WIDTH-1:0]   rob_entries,
    output rename_pkg::b_mask_t                      b_mask,
    input  rename_pkg::cdb_t       [`RN_WIDTH-1:0]   cdb,
    input  logic                                     retire_valid,
    input  rename_pkg::phys_reg_t                    retire_tag,
    input  logic                                     resolve_valid,
    input  rename_pkg::b_id_t                        resolve_id,
    input  logic                                     resolve_mispredict
);
    import rename_pkg::*;

    phys_reg_t [`RN_WIDTH-1:0]    regs_to_use;
    count_t                       free_count, alloc_count;
    reg_vec_t                     free_list, complete_list, restore_free;
    checkpoint_t [`BS_DEPTH-1:0]  new_checkpoints;
    b_mask_t                      bs_alloc;
    logic                         restore_valid;
    map_table_t                   restore_map;

    phys_reg_status i_phys_reg_status (
        .clock, .reset, .alloc_count, .cdb, .retire_valid, .retire_tag,
        .restore_valid, .restore_free, .regs_to_use, .free_count, .free_list, .complete_list
    );

    branch_stack i_branch_stack (
        .clock, .reset, .bs_alloc, .new_checkpoints, .resolve_valid, .resolve_mispredict,
        .resolve_id, .retire_valid, .retire_tag, .b_mask, .restore_valid, .restore_map,
        .restore_free
    );

    dispatch i_dispatch (
        .clock, .reset, .inst_count, .rob_spots, .rs_spots, .free_count, .insts, .regs_to_use,
        .complete_list, .free_list, .cdb, .b_mask, .restore_valid, .restore_map,
        .num_dispatched, .alloc_count, .rs_entries, .rob_entries, .bs_alloc, .new_checkpoints
    );

endmodule
